// ==== all.f ====
verilog/cnn_pkg.sv
verilog/row_deserializer.sv
verilog/conv_sequencer.sv
verilog/position_counter.sv
verilog/conv_datapath.sv
verilog/max_pool_row.sv
verilog/row_serializer.sv
verilog/cnn_top.sv
test/cnn_props.sv
test/cnn_tb.sv

// ==== Bender.yml ====
package:
  name: cnn_filter

sources:
  - files:
      - verilog/cnn_pkg.sv
      - verilog/row_deserializer.sv
      - verilog/conv_sequencer.sv
      - verilog/position_counter.sv
      - verilog/conv_datapath.sv
      - verilog/max_pool_row.sv
      - verilog/row_serializer.sv
      - verilog/cnn_top.sv
  - target: test
    files:
      - test/cnn_props.sv
      - test/cnn_tb.sv

// ==== test/cnn_tb.sv ====
// Streaming image filter testbench
module cnn_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMAGE_WIDTH = 28;
    localparam int IMAGE_HEIGHT = 28;
    localparam int PIXELS = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int OUT_WIDTH = IMAGE_WIDTH / 2;
    localparam int POOL_ROWS = IMAGE_HEIGHT / 2;
    localparam int WORDS = OUT_WIDTH * POOL_ROWS;
    localparam int NUM_TESTS = 8;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * PIXELS * 8 + 2000;

    // Pixel pattern kinds
    localparam int PAT_CONST = 0;
    localparam int PAT_COL_RAMP = 1;
    localparam int PAT_ROW_RAMP = 2;
    localparam int PAT_LFSR = 3;

    typedef struct {
        int kind;
        int value;
        bit stall;
        int expect_const;
    } test_row_t;

    logic clock = 1'b0;
    logic reset;
    cnn_pkg::bus_word_t in_data;
    logic in_valid;
    logic upstream_stall;
    cnn_pkg::bus_word_t out_data;
    logic out_valid;
    logic downstream_stall;

    test_row_t tests [NUM_TESTS];
    cnn_pkg::pixel_t image_mem [NUM_TESTS][PIXELS];
    cnn_pkg::bus_word_t expect_mem [NUM_TESTS][WORDS];
    logic [31:0] src_lfsr = 32'ha121;
    logic [31:0] sink_lfsr = 32'ha121;
    int errors = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int cycle_count = 0;

    cnn_top #(
        .IMAGE_WIDTH(IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT)
    ) dut (
        .clock_i(clock),
        .reset_i(reset),
        .in_data_i(in_data),
        .in_valid_i(in_valid),
        .upstream_stall_o(upstream_stall),
        .out_data_o(out_data),
        .out_valid_o(out_valid),
        .downstream_stall_i(downstream_stall)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the images did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], state[0]};
            state = lfsr_step(state);
        end
    endtask

    function automatic string kind_name(input int kind);
        case (kind)
            PAT_CONST: return "constant";
            PAT_COL_RAMP: return "column ramp";
            PAT_ROW_RAMP: return "row ramp";
            default: return "lfsr";
        endcase
    endfunction

    task automatic check_word(input string name, input cnn_pkg::bus_word_t actual,
                              input cnn_pkg::bus_word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_pixel(input string name, input cnn_pkg::pixel_t actual,
                               input cnn_pkg::pixel_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic load_table();
        tests[0] = '{PAT_CONST, 200, 1'b0, 200};
        tests[1] = '{PAT_CONST, 255, 1'b0, 252};
        tests[2] = '{PAT_COL_RAMP, 9, 1'b0, -1};
        tests[3] = '{PAT_ROW_RAMP, 9, 1'b0, -1};
        tests[4] = '{PAT_LFSR, 0, 1'b0, -1};
        tests[5] = '{PAT_LFSR, 1, 1'b0, -1};
        // Same images as tests 4 and 5 under random stalls
        tests[6] = '{PAT_LFSR, 0, 1'b1, -1};
        tests[7] = '{PAT_LFSR, 1, 1'b1, -1};
    endtask

    // Image pixels and pooled words from the filter rules
    task automatic build_test(input int t);
        logic [31:0] pix_state;
        logic [31:0] bits;
        int conv [IMAGE_HEIGHT][IMAGE_WIDTH];
        int px;
        int best;
        int last_r;
        pix_state = 32'ha121 ^ tests[t].value;
        for (int y = 0; y < IMAGE_HEIGHT; y++) begin
            for (int x = 0; x < IMAGE_WIDTH; x++) begin
                case (tests[t].kind)
                    PAT_CONST: px = tests[t].value;
                    // Falling ramp so the wrapped column wins the last pool column
                    PAT_COL_RAMP: px = (IMAGE_WIDTH - 1 - x) * tests[t].value;
                    PAT_ROW_RAMP: px = y * tests[t].value;
                    default: begin
                        take_bits(pix_state, cnn_pkg::PIXEL_BITS, bits);
                        px = bits;
                    end
                endcase
                image_mem[t][y*IMAGE_WIDTH+x] = cnn_pkg::pixel_t'(px);
            end
        end
        for (int r = 1; r < IMAGE_HEIGHT; r++) begin
            for (int x = 0; x < IMAGE_WIDTH; x++) begin
                conv[r][x] = 0;
                for (int dr = -1; dr <= 0; dr++) begin
                    for (int dc = 0; dc <= 1; dc++) begin
                        px = image_mem[t][(r+dr)*IMAGE_WIDTH + (x+dc) % IMAGE_WIDTH];
                        conv[r][x] += px >> 2;
                    end
                end
            end
        end
        // Pairs of convolution rows with a lone last row pooled by itself
        for (int i = 0; i < POOL_ROWS; i++) begin
            last_r = (2 * i + 2 < IMAGE_HEIGHT) ? 2 * i + 2 : 2 * i + 1;
            for (int j = 0; j < OUT_WIDTH; j++) begin
                best = 0;
                for (int r = 2 * i + 1; r <= last_r; r++) begin
                    for (int c = 2 * j; c <= 2 * j + 1; c++) begin
                        if (conv[r][c] > best) begin
                            best = conv[r][c];
                        end
                    end
                end
                expect_mem[t][i*OUT_WIDTH+j] = cnn_pkg::bus_word_t'(best);
            end
        end
    endtask

    task automatic send_images();
        logic [31:0] bits;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int k = 0; k < PIXELS; k++) begin
                if (tests[t].stall) begin
                    take_bits(src_lfsr, 1, bits);
                    while (bits[0]) begin
                        in_valid <= 1'b0;
                        @(posedge clock);
                        take_bits(src_lfsr, 1, bits);
                    end
                end
                // Upper bits carry the pixel count and must be ignored
                in_data <= (cnn_pkg::bus_word_t'(k) << cnn_pkg::PIXEL_BITS)
                         | cnn_pkg::bus_word_t'(image_mem[t][k]);
                in_valid <= 1'b1;
                do begin
                    @(posedge clock);
                end while (upstream_stall);
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic collect_outputs();
        logic [31:0] bits;
        int t;
        int n;
        t = 0;
        n = 0;
        while (t < NUM_TESTS) begin
            @(posedge clock);
            if (out_valid && !downstream_stall) begin
                check_word("out_data_o", out_data, expect_mem[t][n]);
                if (tests[t].expect_const >= 0) begin
                    check_pixel("out_data_o[7:0]", out_data[cnn_pkg::PIXEL_BITS-1:0],
                                cnn_pkg::pixel_t'(tests[t].expect_const));
                end
                n++;
                if (n == WORDS) begin
                    $display("test %0d %s%s: %0d words, %0d mismatches", t,
                             kind_name(tests[t].kind), tests[t].stall ? " with stalls" : "",
                             n, test_errors);
                    if (test_errors == 0) begin
                        tests_passed++;
                    end
                    test_errors = 0;
                    n = 0;
                    t++;
                end
            end
            if (t < NUM_TESTS && tests[t].stall) begin
                take_bits(sink_lfsr, 1, bits);
                downstream_stall <= bits[0];
            end else begin
                downstream_stall <= 1'b0;
            end
        end
    endtask

    initial begin
        int extra;
        reset = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        downstream_stall = 1'b0;
        extra = 0;
        load_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            build_test(t);
        end
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        fork
            send_images();
            collect_outputs();
        join
        // Nothing may follow the last image
        repeat (200) begin
            @(posedge clock);
            if (out_valid) begin
                extra++;
            end
        end
        if (extra != 0) begin
            $display("The DUT sent output words after the last image was complete");
            errors++;
        end
        $display("%0d tests run, %0d passed, %0d errors", NUM_TESTS, tests_passed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== test/cnn_props.sv ====
// Top level port properties
module cnn_props (
    input logic               clock_i,
    input logic               reset_i,
    input cnn_pkg::bus_word_t out_data_o,
    input logic               out_valid_o,
    input logic               upstream_stall_o,
    input logic               downstream_stall_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Outputs come out of reset quiet
    reset_quiet: assert property (@(posedge clock_i)
        reset_i |=> !out_valid_o && !upstream_stall_o)
        else $error("output valid or input stall high during reset");

    // A stalled word stays put
    stall_hold: assert property (@(posedge clock_i) disable iff (reset_i)
        out_valid_o && downstream_stall_i |=> out_valid_o && $stable(out_data_o))
        else $error("output word changed while stalled");

    // Pixels are zero-extended into the word
    zero_extend: assert property (@(posedge clock_i) disable iff (reset_i)
        out_valid_o |-> out_data_o[cnn_pkg::BUS_BITS-1:cnn_pkg::PIXEL_BITS] == '0)
        else $error("upper bits of output word not zero");

endmodule

bind cnn_top cnn_props u_props (
    .clock_i(clock_i),
    .reset_i(reset_i),
    .out_data_o(out_data_o),
    .out_valid_o(out_valid_o),
    .upstream_stall_o(upstream_stall_o),
    .downstream_stall_i(downstream_stall_i)
);

// ==== verilog/cnn_top.sv ====
// Streaming image filter top
module cnn_top #(
    parameter int IMAGE_WIDTH  = 28,
    parameter int IMAGE_HEIGHT = 28
) (
    input  logic               clock_i,
    input  logic               reset_i,
    input  cnn_pkg::bus_word_t in_data_i,
    input  logic               in_valid_i,
    output logic               upstream_stall_o,
    output cnn_pkg::bus_word_t out_data_o,
    output logic               out_valid_o,
    input  logic               downstream_stall_i
);
    // Deserializer to convolution
    cnn_pkg::pixel_t in_row [IMAGE_WIDTH];
    logic in_row_valid;
    logic in_row_accept;

    // Convolution to pool
    cnn_pkg::pixel_t conv_row [IMAGE_WIDTH];
    logic conv_row_valid;
    logic conv_row_accept;
    logic conv_row_last;

    // Pool to serializer
    cnn_pkg::pixel_t pool_row [IMAGE_WIDTH/2];
    logic pool_row_valid;
    logic pool_row_accept;

    // Convolution control
    logic shift_vert;
    logic shift_horiz;
    logic capture;
    logic col_clear;
    logic col_step;
    logic row_step;
    logic [$clog2(IMAGE_WIDTH)-1:0] col_idx;
    logic col_done;
    logic window_ready;
    logic image_last;

    row_deserializer #(
        .IMAGE_WIDTH(IMAGE_WIDTH)
    ) u_deser (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .in_data_i(in_data_i),
        .in_valid_i(in_valid_i),
        .row_accept_i(in_row_accept),
        .upstream_stall_o(upstream_stall_o),
        .row_o(in_row),
        .row_valid_o(in_row_valid)
    );

    conv_sequencer u_conv_seq (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .row_valid_i(in_row_valid),
        .out_row_accept_i(conv_row_accept),
        .col_done_i(col_done),
        .window_ready_i(window_ready),
        .image_last_i(image_last),
        .row_accept_o(in_row_accept),
        .shift_vert_o(shift_vert),
        .shift_horiz_o(shift_horiz),
        .capture_o(capture),
        .col_clear_o(col_clear),
        .col_step_o(col_step),
        .row_step_o(row_step),
        .out_row_valid_o(conv_row_valid),
        .out_row_last_o(conv_row_last)
    );

    position_counter #(
        .IMAGE_WIDTH(IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT)
    ) u_pos (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .col_clear_i(col_clear),
        .col_step_i(col_step),
        .row_step_i(row_step),
        .col_idx_o(col_idx),
        .col_done_o(col_done),
        .window_ready_o(window_ready),
        .image_last_o(image_last)
    );

    conv_datapath #(
        .IMAGE_WIDTH(IMAGE_WIDTH)
    ) u_conv_dp (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .row_i(in_row),
        .shift_vert_i(shift_vert),
        .shift_horiz_i(shift_horiz),
        .capture_i(capture),
        .col_idx_i(col_idx),
        .out_row_o(conv_row)
    );

    max_pool_row #(
        .IMAGE_WIDTH(IMAGE_WIDTH)
    ) u_pool (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .in_row_i(conv_row),
        .in_row_valid_i(conv_row_valid),
        .in_row_last_i(conv_row_last),
        .out_row_accept_i(pool_row_accept),
        .in_row_accept_o(conv_row_accept),
        .out_row_o(pool_row),
        .out_row_valid_o(pool_row_valid)
    );

    row_serializer #(
        .IMAGE_WIDTH(IMAGE_WIDTH)
    ) u_ser (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .row_i(pool_row),
        .row_valid_i(pool_row_valid),
        .downstream_stall_i(downstream_stall_i),
        .row_accept_o(pool_row_accept),
        .out_data_o(out_data_o),
        .out_valid_o(out_valid_o)
    );

endmodule

// ==== verilog/row_serializer.sv ====
// Output serialization
module row_serializer #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic               clock_i,
    input  logic               reset_i,
    input  cnn_pkg::pixel_t    row_i [IMAGE_WIDTH/2],
    input  logic               row_valid_i,
    input  logic               downstream_stall_i,
    output logic               row_accept_o,
    output cnn_pkg::bus_word_t out_data_o,
    output logic               out_valid_o
);
    localparam int OUT_WIDTH = IMAGE_WIDTH / 2;
    localparam int IDX_BITS = $clog2(OUT_WIDTH);

    cnn_pkg::pixel_t row_q [OUT_WIDTH];
    logic [IDX_BITS-1:0] rd_idx_q;
    logic busy_q;

    assign row_accept_o = !busy_q && row_valid_i;
    assign out_valid_o = busy_q;
    assign out_data_o = cnn_pkg::bus_word_t'(row_q[rd_idx_q]);

    always_ff @(posedge clock_i) begin
        if (row_accept_o) begin
            row_q <= row_i;
        end
    end

    // The read index only moves when the sink takes the word
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            rd_idx_q <= '0;
        end else if (row_accept_o) begin
            busy_q <= 1'b1;
            rd_idx_q <= '0;
        end else if (busy_q && !downstream_stall_i) begin
            if (rd_idx_q == IDX_BITS'(OUT_WIDTH - 1)) begin
                busy_q <= 1'b0;
                rd_idx_q <= '0;
            end else begin
                rd_idx_q <= rd_idx_q + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/max_pool_row.sv ====
// Row max pooling
module max_pool_row #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic            clock_i,
    input  logic            reset_i,
    input  cnn_pkg::pixel_t in_row_i [IMAGE_WIDTH],
    input  logic            in_row_valid_i,
    input  logic            in_row_last_i,
    input  logic            out_row_accept_i,
    output logic            in_row_accept_o,
    output cnn_pkg::pixel_t out_row_o [IMAGE_WIDTH/2],
    output logic            out_row_valid_o
);
    localparam int OUT_WIDTH = IMAGE_WIDTH / 2;
    localparam int POS_BITS = $clog2(OUT_WIDTH);

    cnn_pkg::pool_state_e state_q;
    cnn_pkg::pixel_t in_q [IMAGE_WIDTH];
    cnn_pkg::pixel_t out_q [OUT_WIDTH];
    logic [POS_BITS-1:0] pos_q;
    logic pos_end;
    // Set once the first row of a pair has been folded
    logic second_q;
    logic last_q;
    cnn_pkg::pixel_t left_px;
    cnn_pkg::pixel_t right_px;
    cnn_pkg::pixel_t best_px;

    assign in_row_accept_o = (state_q == cnn_pkg::POOL_GET_ROW) && in_row_valid_i;
    assign out_row_valid_o = (state_q == cnn_pkg::POOL_WAIT_READ);
    assign out_row_o = out_q;
    assign pos_end = (pos_q == POS_BITS'(OUT_WIDTH - 1));

    // Largest of the stored maximum and the two pixels under it
    always_comb begin
        left_px = in_q[2 * pos_q];
        right_px = in_q[2 * pos_q + 1];
        best_px = out_q[pos_q];
        if (left_px > best_px) begin
            best_px = left_px;
        end
        if (right_px > best_px) begin
            best_px = right_px;
        end
    end

    always_ff @(posedge clock_i) begin
        if (in_row_accept_o) begin
            in_q <= in_row_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= cnn_pkg::POOL_GET_ROW;
            pos_q <= '0;
            second_q <= 1'b0;
            last_q <= 1'b0;
            out_q <= '{default: '0};
        end else begin
            case (state_q)
                cnn_pkg::POOL_GET_ROW: begin
                    if (in_row_valid_i) begin
                        last_q <= in_row_last_i;
                        pos_q <= '0;
                        state_q <= cnn_pkg::POOL_CALC;
                    end
                end
                cnn_pkg::POOL_CALC: begin
                    out_q[pos_q] <= best_px;
                    pos_q <= pos_q + 1'b1;
                    if (pos_end) begin
                        if (second_q || last_q) begin
                            state_q <= cnn_pkg::POOL_WAIT_READ;
                        end else begin
                            second_q <= 1'b1;
                            state_q <= cnn_pkg::POOL_GET_ROW;
                        end
                    end
                end
                cnn_pkg::POOL_WAIT_READ: begin
                    if (out_row_accept_i) begin
                        out_q <= '{default: '0};
                        second_q <= 1'b0;
                        state_q <= cnn_pkg::POOL_GET_ROW;
                    end
                end
                default: state_q <= cnn_pkg::POOL_GET_ROW;
            endcase
        end
    end

endmodule

// ==== verilog/conv_datapath.sv ====
// Convolution window and kernel
module conv_datapath #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic                           clock_i,
    input  logic                           reset_i,
    input  cnn_pkg::pixel_t                row_i [IMAGE_WIDTH],
    input  logic                           shift_vert_i,
    input  logic                           shift_horiz_i,
    input  logic                           capture_i,
    input  logic [$clog2(IMAGE_WIDTH)-1:0] col_idx_i,
    output cnn_pkg::pixel_t                out_row_o [IMAGE_WIDTH]
);
    localparam int K = cnn_pkg::KERNEL_SIZE;
    localparam int PROD_BITS = cnn_pkg::PIXEL_BITS + cnn_pkg::WEIGHT_BITS;
    localparam int ACC_BITS = cnn_pkg::PIXEL_BITS + $clog2(K * K);

    // Row 0 holds the newest row
    cnn_pkg::pixel_t win_q [K][IMAGE_WIDTH];
    cnn_pkg::pixel_t out_row_q [IMAGE_WIDTH];
    cnn_pkg::pixel_t kernel_q;
    logic [PROD_BITS-1:0] prod;
    logic [ACC_BITS-1:0] acc;

    assign out_row_o = out_row_q;

    always_ff @(posedge clock_i) begin
        if (shift_vert_i) begin
            for (int r = 1; r < K; r++) begin
                win_q[r] <= win_q[r-1];
            end
            win_q[0] <= row_i;
        end else if (shift_horiz_i) begin
            // Rotate left so column 0 wraps round to the end
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < IMAGE_WIDTH - 1; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
                win_q[r][IMAGE_WIDTH-1] <= win_q[r][0];
            end
        end
    end

    // Weighted sum over the leftmost K by K taps
    always_comb begin
        acc = '0;
        prod = '0;
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                prod = PROD_BITS'(cnn_pkg::KERNEL_WEIGHT) * PROD_BITS'(win_q[r][c]);
                acc = acc + ACC_BITS'(prod >> cnn_pkg::WEIGHT_Q_SHIFT);
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            kernel_q <= '0;
        end else begin
            kernel_q <= acc[cnn_pkg::PIXEL_BITS-1:0];
        end
    end

    always_ff @(posedge clock_i) begin
        if (capture_i) begin
            out_row_q[col_idx_i] <= kernel_q;
        end
    end

endmodule

// ==== verilog/position_counter.sv ====
// Column and image row counters
module position_counter #(
    parameter int IMAGE_WIDTH  = 28,
    parameter int IMAGE_HEIGHT = 28
) (
    input  logic                           clock_i,
    input  logic                           reset_i,
    input  logic                           col_clear_i,
    input  logic                           col_step_i,
    input  logic                           row_step_i,
    output logic [$clog2(IMAGE_WIDTH)-1:0] col_idx_o,
    output logic                           col_done_o,
    output logic                           window_ready_o,
    output logic                           image_last_o
);
    localparam int COL_BITS = $clog2(IMAGE_WIDTH);
    localparam int ROW_BITS = $clog2(IMAGE_HEIGHT + 1);

    logic [COL_BITS-1:0] col_q;
    // Rows received so far in the current image
    logic [ROW_BITS-1:0] rows_q;

    assign col_idx_o = col_q;
    assign col_done_o = (col_q == COL_BITS'(IMAGE_WIDTH - 1));
    assign window_ready_o = (rows_q >= ROW_BITS'(cnn_pkg::KERNEL_SIZE));
    assign image_last_o = (rows_q == ROW_BITS'(IMAGE_HEIGHT));

    always_ff @(posedge clock_i) begin
        if (reset_i || col_clear_i) begin
            col_q <= '0;
        end else if (col_step_i) begin
            col_q <= col_done_o ? '0 : col_q + 1'b1;
        end
    end

    // After a full image the count restarts with the new row as the first
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            rows_q <= '0;
        end else if (row_step_i) begin
            rows_q <= image_last_o ? ROW_BITS'(1) : rows_q + 1'b1;
        end
    end

endmodule

// ==== verilog/conv_sequencer.sv ====
// Convolution row sequencer
module conv_sequencer (
    input  logic clock_i,
    input  logic reset_i,
    input  logic row_valid_i,
    input  logic out_row_accept_i,
    input  logic col_done_i,
    input  logic window_ready_i,
    input  logic image_last_i,
    output logic row_accept_o,
    output logic shift_vert_o,
    output logic shift_horiz_o,
    output logic capture_o,
    output logic col_clear_o,
    output logic col_step_o,
    output logic row_step_o,
    output logic out_row_valid_o,
    output logic out_row_last_o
);
    cnn_pkg::layer_state_e state_q;
    cnn_pkg::layer_state_e state_d;
    logic last_q;

    assign out_row_valid_o = (state_q == cnn_pkg::LAYER_WAIT_READ);
    assign out_row_last_o = last_q;

    always_comb begin
        state_d = state_q;
        row_accept_o = 1'b0;
        shift_vert_o = 1'b0;
        shift_horiz_o = 1'b0;
        capture_o = 1'b0;
        col_clear_o = 1'b0;
        col_step_o = 1'b0;
        row_step_o = 1'b0;
        case (state_q)
            cnn_pkg::LAYER_GET_ROW: begin
                if (row_valid_i) begin
                    row_accept_o = 1'b1;
                    shift_vert_o = 1'b1;
                    row_step_o = 1'b1;
                    col_clear_o = 1'b1;
                    state_d = cnn_pkg::LAYER_CALC_WAIT;
                end
            end
            // Kernel register settles here; first pass also checks the window
            cnn_pkg::LAYER_CALC_WAIT: begin
                state_d = window_ready_i ? cnn_pkg::LAYER_CALC : cnn_pkg::LAYER_GET_ROW;
            end
            cnn_pkg::LAYER_CALC: begin
                capture_o = 1'b1;
                shift_horiz_o = 1'b1;
                col_step_o = 1'b1;
                state_d = col_done_i ? cnn_pkg::LAYER_WAIT_READ : cnn_pkg::LAYER_CALC_WAIT;
            end
            cnn_pkg::LAYER_WAIT_READ: begin
                if (out_row_accept_i) begin
                    state_d = cnn_pkg::LAYER_GET_ROW;
                end
            end
            default: state_d = cnn_pkg::LAYER_GET_ROW;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= cnn_pkg::LAYER_GET_ROW;
            last_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Tag the finished row with the image position
            if (state_q == cnn_pkg::LAYER_CALC && col_done_i) begin
                last_q <= image_last_i;
            end
        end
    end

endmodule

// ==== verilog/row_deserializer.sv ====
// Input row assembly
module row_deserializer #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic                  clock_i,
    input  logic                  reset_i,
    input  cnn_pkg::bus_word_t    in_data_i,
    input  logic                  in_valid_i,
    input  logic                  row_accept_i,
    output logic                  upstream_stall_o,
    output cnn_pkg::pixel_t       row_o [IMAGE_WIDTH],
    output logic                  row_valid_o
);
    localparam int IDX_BITS = $clog2(IMAGE_WIDTH);

    cnn_pkg::pixel_t row_q [IMAGE_WIDTH];
    logic [IDX_BITS-1:0] fill_idx_q;
    logic full_q;
    logic take_word;

    // A word is taken only while there is room for it
    assign take_word = in_valid_i && !full_q;

    assign upstream_stall_o = full_q;
    assign row_valid_o = full_q;
    assign row_o = row_q;

    always_ff @(posedge clock_i) begin
        if (take_word) begin
            row_q[fill_idx_q] <= in_data_i[cnn_pkg::PIXEL_BITS-1:0];
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            fill_idx_q <= '0;
            full_q <= 1'b0;
        end else if (take_word) begin
            if (fill_idx_q == IDX_BITS'(IMAGE_WIDTH - 1)) begin
                fill_idx_q <= '0;
                full_q <= 1'b1;
            end else begin
                fill_idx_q <= fill_idx_q + 1'b1;
            end
        end else if (row_accept_i) begin
            full_q <= 1'b0;
        end
    end

endmodule

// ==== verilog/cnn_pkg.sv ====
// CNN filter shared definitions
package cnn_pkg;

    // Stream and pixel widths
    localparam int BUS_BITS = 32;
    localparam int PIXEL_BITS = 8;

    typedef logic [PIXEL_BITS-1:0] pixel_t;
    typedef logic [BUS_BITS-1:0] bus_word_t;

    // Fixed-point kernel weights
    localparam int WEIGHT_BITS = 8;
    localparam int WEIGHT_Q_SHIFT = 6;
    localparam int KERNEL_SIZE = 2;

    typedef logic [WEIGHT_BITS-1:0] weight_t;

    // One in Q6 spread evenly over the four taps
    localparam weight_t KERNEL_WEIGHT =
        weight_t'((1 << WEIGHT_Q_SHIFT) / (KERNEL_SIZE * KERNEL_SIZE));

    // Convolution layer states
    typedef enum logic [1:0] {
        LAYER_GET_ROW   = 2'd0,
        LAYER_CALC_WAIT = 2'd1,
        LAYER_CALC      = 2'd2,
        LAYER_WAIT_READ = 2'd3
    } layer_state_e;

    // Pooling layer states
    typedef enum logic [1:0] {
        POOL_GET_ROW   = 2'd0,
        POOL_CALC      = 2'd1,
        POOL_WAIT_READ = 2'd2
    } pool_state_e;

endpackage
